//--- verilog/mpArithPkg.sv
`default_nettype none

package mpArithPkg;

  // opcodes. the reserved code decodes as OP_ADD.
  typedef enum logic [1:0] {
    OP_ADD    = 2'd0,
    OP_SUB    = 2'd1,
    OP_MODADD = 2'd2,
    OP_RSVD   = 2'd3
  } mpOp;

  // sequencer states.
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    PASS1 = 3'd1,
    WAIT1 = 3'd2,
    PASS2 = 3'd3,
    WAIT2 = 3'd4
  } mpState;

endpackage

`default_nettype wire

//--- verilog/mpCmdDecode.sv
`timescale 1ns/1ps
`default_nettype none

module mpCmdDecode #(
  parameter int WIDTH = 1029
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  mpArithPkg::mpOp op,
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic [WIDTH-1:0] m,
  input  logic            done,
  output logic            busy,
  output logic            go,
  output mpArithPkg::mpOp cmdOp,
  output logic [WIDTH:0]  opA,
  output logic [WIDTH:0]  opB,
  output logic            cin,
  output logic [WIDTH:0]  modulus
);

  logic            accept;
  mpArithPkg::mpOp opMapped;

  // starts while busy are dropped here.
  assign accept   = start && !busy;
  assign opMapped = (op == mpArithPkg::OP_RSVD) ? mpArithPkg::OP_ADD : op;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      go    <= 1'b0;
      cin   <= 1'b0;
      cmdOp <= mpArithPkg::OP_ADD;
    end else begin
      go <= accept;
      if (accept) begin
        busy  <= 1'b1;
        cin   <= (opMapped == mpArithPkg::OP_SUB);
        cmdOp <= opMapped;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // sub is a + ~b + 1.
  always_ff @(posedge clk) begin
    if (accept) begin
      opA     <= {1'b0, a};
      opB     <= (opMapped == mpArithPkg::OP_SUB) ? ~{1'b0, b} : {1'b0, b};
      modulus <= {1'b0, m};
    end
  end

  goOnlyFromIdle: assert property (@(posedge clk) disable iff (reset)
    go |-> !$past(busy))
    else $error("go issued for a start that arrived while busy");

endmodule

`default_nettype wire

//--- verilog/mpAdderC.sv
`timescale 1ns/1ps
`default_nettype none

module mpAdderC #(
  parameter int WIDTH = 1029,
  parameter int CHUNK = 64
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH:0]   inA,
  input  logic [WIDTH:0]   inB,
  input  logic             cin,
  output logic [WIDTH+1:0] sum
);

  localparam int IW  = WIDTH + 1;
  // top chunk absorbs the leftover bits.
  localparam int NCH = IW / CHUNK;

  // selected carry out of each chunk.
  logic [NCH:1] cy;

  for (genvar i = 0; i < NCH; i++) begin : gChunk
    localparam int LO = i * CHUNK;
    localparam int HI = (i == NCH - 1) ? IW - 1 : LO + CHUNK - 1;
    localparam int CW = HI - LO + 1;

    logic [CW:0]   add0;
    logic [CW-1:0] s0Reg;
    logic          c0Reg;

    always_ff @(posedge clk) begin
      s0Reg <= add0[CW-1:0];
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        c0Reg <= 1'b0;
      end else begin
        c0Reg <= add0[CW];
      end
    end

    if (i == 0) begin : gLow
      // lowest chunk takes the real carry-in.
      assign add0 = {1'b0, inA[HI:LO]} + {1'b0, inB[HI:LO]} + {{CW{1'b0}}, cin};

      assign sum[HI:LO] = s0Reg;
      assign cy[1]      = c0Reg;
    end else begin : gHigh
      logic [CW:0]   add1;
      logic [CW-1:0] s1Reg;
      logic          c1Reg;

      assign add0 = {1'b0, inA[HI:LO]} + {1'b0, inB[HI:LO]};
      assign add1 = {1'b0, inA[HI:LO]} + {1'b0, inB[HI:LO]} + {{CW{1'b0}}, 1'b1};

      always_ff @(posedge clk) begin
        s1Reg <= add1[CW-1:0];
      end

      always_ff @(posedge clk) begin
        if (reset) begin
          c1Reg <= 1'b0;
        end else begin
          c1Reg <= add1[CW];
        end
      end

      // carry ripple picks the precomputed half.
      assign sum[HI:LO] = cy[i] ? s1Reg : s0Reg;
      assign cy[i+1]    = cy[i] ? c1Reg : c0Reg;
    end
  end

  assign sum[IW] = cy[NCH];

  cinKnown: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(cin))
    else $error("adder carry-in is unknown");

endmodule

`default_nettype wire

//--- verilog/mpExecute.sv
`timescale 1ns/1ps
`default_nettype none

module mpExecute #(
  parameter int WIDTH = 1029,
  parameter int CHUNK = 64
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            go,
  input  mpArithPkg::mpOp cmdOp,
  input  logic [WIDTH:0]  opA,
  input  logic [WIDTH:0]  opB,
  input  logic            cin,
  input  logic [WIDTH:0]  modulus,
  output logic [WIDTH:0]  pass1Sum,
  output logic [WIDTH:0]  pass2Sum,
  output logic            pass2Carry,
  output logic            finish,
  output mpArithPkg::mpOp finOp
);

  mpArithPkg::mpState state;
  logic [WIDTH:0]     addA;
  logic [WIDTH:0]     addB;
  logic               addCin;
  logic [WIDTH+1:0]   sum;

  // second pass forms pass1Sum - m.
  always_comb begin
    if (state == mpArithPkg::PASS2) begin
      addA   = pass1Sum;
      addB   = ~modulus;
      addCin = 1'b1;
    end else if (go) begin
      addA   = opA;
      addB   = opB;
      addCin = cin;
    end else begin
      addA   = '0;
      addB   = '0;
      addCin = 1'b0;
    end
  end

  mpAdderC #(
    .WIDTH(WIDTH),
    .CHUNK(CHUNK)
  ) uAdder (
    .clk  (clk),
    .reset(reset),
    .inA  (addA),
    .inB  (addB),
    .cin  (addCin),
    .sum  (sum)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= mpArithPkg::IDLE;
      finish <= 1'b0;
      finOp  <= mpArithPkg::OP_ADD;
    end else begin
      finish <= 1'b0;
      case (state)
        mpArithPkg::IDLE: begin
          if (go) begin
            state <= mpArithPkg::PASS1;
            finOp <= cmdOp;
          end
        end
        mpArithPkg::PASS1: begin
          if (finOp == mpArithPkg::OP_MODADD) begin
            state <= mpArithPkg::PASS2;
          end else begin
            state  <= mpArithPkg::WAIT1;
            finish <= 1'b1;
          end
        end
        mpArithPkg::WAIT1: state <= mpArithPkg::IDLE;
        mpArithPkg::PASS2: state <= mpArithPkg::WAIT2;
        // first cycle captures, second one carries finish.
        mpArithPkg::WAIT2: begin
          if (finish) begin
            state <= mpArithPkg::IDLE;
          end else begin
            finish <= 1'b1;
          end
        end
        default: state <= mpArithPkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mpArithPkg::PASS1) begin
      pass1Sum <= sum[WIDTH:0];
    end
    if (state == mpArithPkg::WAIT2 && !finish) begin
      pass2Sum   <= sum[WIDTH:0];
      pass2Carry <= sum[WIDTH+1];
    end
  end

  finishState: assert property (@(posedge clk) disable iff (reset)
    finish |-> ((state == mpArithPkg::WAIT1 && finOp != mpArithPkg::OP_MODADD) ||
                state == mpArithPkg::WAIT2))
    else $error("finish outside WAIT1/WAIT2");

endmodule

`default_nettype wire

//--- verilog/mpResult.sv
`timescale 1ns/1ps
`default_nettype none

module mpResult #(
  parameter int WIDTH = 1029
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            finish,
  input  mpArithPkg::mpOp finOp,
  input  logic [WIDTH:0]  pass1Sum,
  input  logic [WIDTH:0]  pass2Sum,
  input  logic            pass2Carry,
  output logic [WIDTH:0]  result,
  output logic            done
);

  logic [WIDTH:0] chosen;

  // no borrow means the sum reached m.
  always_comb begin
    if (finOp == mpArithPkg::OP_MODADD && pass2Carry) begin
      chosen = pass2Sum;
    end else begin
      chosen = pass1Sum;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      done   <= 1'b0;
    end else begin
      done <= finish;
      if (finish) begin
        result <= chosen;
      end
    end
  end

  donePulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else $error("done high twice, finish held past one WAIT1/WAIT2 cycle");

endmodule

`default_nettype wire

//--- verilog/mpArithTop.sv
`timescale 1ns/1ps
`default_nettype none

module mpArithTop #(
  parameter int WIDTH = 1029,
  parameter int CHUNK = 64
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  mpArithPkg::mpOp  op,
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic [WIDTH-1:0] m,
  output logic [WIDTH:0]   result,
  output logic             done,
  output logic             busy
);

  logic            go;
  mpArithPkg::mpOp cmdOp;
  logic [WIDTH:0]  opA;
  logic [WIDTH:0]  opB;
  logic            cin;
  logic [WIDTH:0]  modulus;
  logic [WIDTH:0]  pass1Sum;
  logic [WIDTH:0]  pass2Sum;
  logic            pass2Carry;
  logic            finish;
  mpArithPkg::mpOp finOp;

  mpCmdDecode #(
    .WIDTH(WIDTH)
  ) uDecode (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .op     (op),
    .a      (a),
    .b      (b),
    .m      (m),
    .done   (done),
    .busy   (busy),
    .go     (go),
    .cmdOp  (cmdOp),
    .opA    (opA),
    .opB    (opB),
    .cin    (cin),
    .modulus(modulus)
  );

  mpExecute #(
    .WIDTH(WIDTH),
    .CHUNK(CHUNK)
  ) uExecute (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .cmdOp     (cmdOp),
    .opA       (opA),
    .opB       (opB),
    .cin       (cin),
    .modulus   (modulus),
    .pass1Sum  (pass1Sum),
    .pass2Sum  (pass2Sum),
    .pass2Carry(pass2Carry),
    .finish    (finish),
    .finOp     (finOp)
  );

  mpResult #(
    .WIDTH(WIDTH)
  ) uResult (
    .clk       (clk),
    .reset     (reset),
    .finish    (finish),
    .finOp     (finOp),
    .pass1Sum  (pass1Sum),
    .pass2Sum  (pass2Sum),
    .pass2Carry(pass2Carry),
    .result    (result),
    .done      (done)
  );

endmodule

`default_nettype wire

//--- sim/mpArithTb.sv
`timescale 1ns/1ps
`default_nettype none

module mpArithTb;

  localparam int WIDTH   = 1029;
  localparam int TIMEOUT = 20;

  logic             clk;
  logic             reset;
  logic             start;
  mpArithPkg::mpOp  op;
  logic [WIDTH-1:0] a;
  logic [WIDTH-1:0] b;
  logic [WIDTH-1:0] m;
  logic [WIDTH:0]   result;
  logic             done;
  logic             busy;

  int checks;
  int errors;
  int testChecks;
  int testErrors;
  int testsRun;
  bit aborted;

  mpArithTop UUT (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .op    (op),
    .a     (a),
    .b     (b),
    .m     (m),
    .result(result),
    .done  (done),
    .busy  (busy)
  );

  always #5 clk = ~clk;

  // wide value from 32-bit words, optionally rich in all-ones words.
  function automatic logic [WIDTH-1:0] randWide(input bit denseOnes);
    logic [1055:0] raw;
    for (int i = 0; i < 33; i++) begin
      if (denseOnes && ($urandom % 4 == 0)) begin
        raw[i*32 +: 32] = 32'hFFFF_FFFF;
      end else begin
        raw[i*32 +: 32] = $urandom;
      end
    end
    return raw[WIDTH-1:0];
  endfunction

  function automatic logic [WIDTH:0] modelAdd(input logic [WIDTH-1:0] x,
                                              input logic [WIDTH-1:0] y);
    return {1'b0, x} + {1'b0, y};
  endfunction

  function automatic logic [WIDTH:0] modelSub(input logic [WIDTH-1:0] x,
                                              input logic [WIDTH-1:0] y);
    return {1'b0, x} - {1'b0, y};
  endfunction

  function automatic logic [WIDTH:0] modelModAdd(input logic [WIDTH-1:0] x,
                                                 input logic [WIDTH-1:0] y,
                                                 input logic [WIDTH-1:0] mod);
    logic [WIDTH:0] s;
    s = {1'b0, x} + {1'b0, y};
    return s % {1'b0, mod};
  endfunction

  task automatic checkValue(input string name, input logic [WIDTH:0] expVal,
                            input logic [WIDTH:0] got);
    testChecks++;
    if (got !== expVal) begin
      $display("Fail %s: expected %h actual %h", name, expVal, got);
      testErrors++;
    end
  endtask

  // latency counted in rising edges after the start edge.
  task automatic waitDone(input string name, output int lat, output logic [WIDTH:0] value);
    lat   = 0;
    value = '0;
    while (!aborted) begin
      @(negedge clk);
      if (done) begin
        value = result;
        break;
      end
      lat++;
      if (lat > TIMEOUT) begin
        $display("%s: no done from the DUT within %0d cycles, run stopped", name, TIMEOUT);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic runCmd(input string name, input mpArithPkg::mpOp cmd,
                        input logic [WIDTH-1:0] x, input logic [WIDTH-1:0] y,
                        input logic [WIDTH-1:0] mod, input int expLat,
                        input logic [WIDTH:0] expVal);
    int             lat;
    logic [WIDTH:0] got;
    if (aborted) begin
      return;
    end
    @(posedge clk);
    start <= 1'b1;
    op    <= cmd;
    a     <= x;
    b     <= y;
    m     <= mod;
    @(posedge clk);
    start <= 1'b0;
    waitDone(name, lat, got);
    if (aborted) begin
      return;
    end
    checkValue(name, expVal, got);
    testChecks++;
    if (lat != expLat) begin
      $display("Fail %s latency: expected %0d actual %0d", name, expLat, lat);
      testErrors++;
    end
  endtask

  task automatic endTest(input string name);
    $display("%s: %0d checks, %0d errors", name, testChecks, testErrors);
    checks     += testChecks;
    errors     += testErrors;
    testChecks = 0;
    testErrors = 0;
    testsRun++;
  endtask

  initial begin
    logic [WIDTH-1:0] x;
    logic [WIDTH-1:0] y;
    logic [WIDTH-1:0] mod;
    logic [WIDTH:0]   expVal;
    logic [WIDTH:0]   got;
    int               doneCount;

    clk        = 1'b0;
    reset      = 1'b1;
    start      = 1'b0;
    op         = mpArithPkg::OP_ADD;
    a          = '0;
    b          = '0;
    m          = '0;
    checks     = 0;
    errors     = 0;
    testChecks = 0;
    testErrors = 0;
    testsRun   = 0;
    aborted    = 1'b0;
    void'($urandom(17570));

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    testChecks++;
    if (done !== 1'b0 || busy !== 1'b0) begin
      $display("Fail RESET: expected done 0 busy 0 actual done %b busy %b", done, busy);
      testErrors++;
    end
    checkValue("RESET", '0, result);
    endTest("RESET");

    // ones across one chunk plus one at its base carries into the next chunk.
    for (int k = 0; k * 64 < WIDTH; k++) begin
      x = {{(WIDTH-64){1'b0}}, 64'hFFFF_FFFF_FFFF_FFFF} << (k * 64);
      y = '0;
      y[k*64] = 1'b1;
      runCmd("ADD", mpArithPkg::OP_ADD, x, y, '0, 3, modelAdd(x, y));
    end
    x = '1;
    y = '0;
    y[0] = 1'b1;
    runCmd("ADD", mpArithPkg::OP_ADD, x, y, '0, 3, modelAdd(x, y));
    runCmd("ADD", mpArithPkg::OP_ADD, x, x, '0, 3, modelAdd(x, x));
    for (int i = 0; i < 200; i++) begin
      x = randWide(1'b1);
      y = randWide(1'b1);
      runCmd("ADD", mpArithPkg::OP_ADD, x, y, '0, 3, modelAdd(x, y));
    end
    endTest("ADD");

    for (int i = 0; i < 200; i++) begin
      x = randWide(1'b0);
      y = randWide(1'b0);
      if (i % 10 == 0) begin
        y = x;
      end else if (i % 2 == 1 && y < x) begin
        // force b above a.
        y = x;
        x = randWide(1'b0) >> 1;
      end
      runCmd("SUB", mpArithPkg::OP_SUB, x, y, '0, 3, modelSub(x, y));
    end
    endTest("SUB");

    for (int i = 0; i < 200; i++) begin
      mod = randWide(1'b0) >> ($urandom % WIDTH);
      if (mod < 2) begin
        mod = 2;
      end
      case (i % 10)
        // sum lands exactly on m.
        0: begin
          x = 1 + randWide(1'b0) % (mod - 1);
          y = mod - x;
        end
        // sum one below m.
        1: begin
          x = randWide(1'b0) % mod;
          y = mod - 1 - x;
        end
        2: begin
          mod = '1;
          x   = mod - 1;
          y   = mod - 1;
        end
        default: begin
          x = randWide(1'b0) % mod;
          y = randWide(1'b0) % mod;
        end
      endcase
      runCmd("MODADD", mpArithPkg::OP_MODADD, x, y, mod, 5, modelModAdd(x, y, mod));
    end
    endTest("MODADD");

    if (!aborted) begin
      x      = randWide(1'b0);
      y      = randWide(1'b0);
      expVal = modelAdd(x, y);
      @(posedge clk);
      start <= 1'b1;
      op    <= mpArithPkg::OP_ADD;
      a     <= x;
      b     <= y;
      m     <= '0;
      @(posedge clk);
      // second command held for three edges while busy, the last one after the FSM is idle.
      op <= mpArithPkg::OP_SUB;
      a  <= randWide(1'b0);
      b  <= randWide(1'b0);
      repeat (3) @(posedge clk);
      start     <= 1'b0;
      doneCount = 0;
      got       = '0;
      for (int n = 0; n < 12; n++) begin
        @(negedge clk);
        if (done) begin
          doneCount++;
          if (doneCount == 1) begin
            got = result;
          end
        end
      end
      testChecks++;
      if (doneCount != 1) begin
        $display("Fail BUSY done count: expected 1 actual %0d", doneCount);
        testErrors++;
      end
      checkValue("BUSY", expVal, got);
      testChecks++;
      if (busy !== 1'b0) begin
        $display("BUSY: busy still high after the only command finished");
        testErrors++;
      end
    end
    endTest("BUSY");

    for (int i = 0; i < 20; i++) begin
      x = randWide(1'b1);
      y = randWide(1'b1);
      runCmd("RSVD", mpArithPkg::OP_RSVD, x, y, '0, 3, modelAdd(x, y));
    end
    endTest("RSVD");

    $display("tests %0d, checks %0d, errors %0d, timeout %0d",
             testsRun, checks, errors, aborted);
    if (errors == 0 && !aborted) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
verilog/mpArithPkg.sv
verilog/mpCmdDecode.sv
verilog/mpAdderC.sv
verilog/mpExecute.sv
verilog/mpResult.sv
verilog/mpArithTop.sv
sim/mpArithTb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module mpArithTb -f all.f -o mpArithSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/mpArithSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
